//--- Bender.yml
package:
  name: hsi_vector_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - hsi_types_pkg.sv
      - hsi_ctrl_pkg.sv
      - vec_fifo.sv
      - vector_decode.sv
      - vector_execute.sv
      - result_writer.sv
      - hsi_vector_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - hsi_vector_core_properties.sv
      - tb_hsi_vector_core.sv

//--- filelist.f
+incdir+.
hsi_types_pkg.sv
hsi_ctrl_pkg.sv
vec_fifo.sv
vector_decode.sv
vector_execute.sv
result_writer.sv
hsi_vector_core.sv
tb_clock_gen.sv
hsi_vector_core_properties.sv
tb_hsi_vector_core.sv

//--- hsi_core_settings.svh
// Size constants of the vector core, pulled in with `include by the packages and the FIFO
`ifndef HSI_CORE_SETTINGS_SVH
`define HSI_CORE_SETTINGS_SVH

// Width of one signed band value
`define HSI_COMP_W 16

// Bands carried in one pixel word
`define HSI_COMP_MAX 3

// Entries in each of the three FIFOs
`define HSI_FIFO_DEPTH 16

`endif

//--- hsi_ctrl_pkg.sv
// Control encodings of the vector core (op codes, error codes, decode states), imported by the RTL
`default_nettype none

package hsi_ctrl_pkg;

`include "hsi_core_settings.svh"

    localparam int unsigned BANDS_MAX   = `HSI_COMP_MAX; // Upper bound for num_bands
    localparam logic [1:0]  CROSS_BANDS = 2'd3;          // Cross product is 3-D only

    typedef enum logic [3:0] {
        OP_CROSS = 4'd1, // Vector product, three bands
        OP_DOT   = 4'd2  // Scalar product, one to three bands
    } op_code_t;

    typedef enum logic [3:0] {
        ERR_NONE        = 4'd0,
        ERR_OP          = 4'd1, // Unknown op or cross without three bands
        ERR_INPUT_EMPTY = 4'd2, // An input FIFO had no pixel at start
        ERR_BANDS       = 4'd4  // num_bands out of range
    } err_code_t;

    typedef enum logic [2:0] {
        IDLE,      // Waiting for start
        FETCH,     // Read data arrives from the input FIFOs
        ISSUE,     // Command handed to execute
        WAIT_DONE, // Waiting for the result write
        ERROR      // Error code held until start drops
    } decode_state_t;

endpackage

`default_nettype wire

//--- hsi_types_pkg.sv
// Data types of the vector core (components, pixel words, results, commands), imported by the RTL
`default_nettype none

package hsi_types_pkg;

`include "hsi_core_settings.svh"

    typedef logic signed [`HSI_COMP_W-1:0] comp_t; // One band value, two's complement

    // Pixel word, component k sits at bit k*W
    typedef comp_t [`HSI_COMP_MAX-1:0] hsi_vec_t;

    // Dot product view of the result word
    typedef struct packed {
        logic [(`HSI_COMP_MAX-1)*`HSI_COMP_W-1:0] pad; // Upper components, always zero
        comp_t                                    sum; // Wrapped sum in component 0
    } dot_view_t;

    // Result word seen either as three components or as a sum
    typedef union packed {
        hsi_vec_t  vec; // Cross product components
        dot_view_t dot; // Dot product sum
    } hsi_result_u;

    // Work item from decode to execute
    typedef struct packed {
        logic [1:0] op;    // Low bits of the op code
        logic [1:0] bands; // Bands in use, 1 to 3
        hsi_vec_t   vec_a; // Pixel from input 1
        hsi_vec_t   vec_b; // Pixel from input 2
    } vec_cmd_t;

endpackage

`default_nettype wire

//--- hsi_vector_core.sv
// Top level of the HSI vector core: input and output FIFOs around decode, execute and writer
`timescale 1ns/1ns
`default_nettype none

module hsi_vector_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in1_wr_en,
    input  hsi_types_pkg::hsi_vec_t in1_data,   // Pixel stream A
    input  logic                    in2_wr_en,
    input  hsi_types_pkg::hsi_vec_t in2_data,   // Pixel stream B
    input  logic                    out_rd_en,
    input  hsi_ctrl_pkg::op_code_t  op_code,
    input  logic [1:0]              num_bands,
    input  logic                    start,
    output logic                    in1_full,
    output logic                    in2_full,
    output hsi_types_pkg::hsi_vec_t out_data,   // Result word, valid after a read
    output logic                    out_empty,
    output logic                    out_full,
    output logic                    pixel_done,
    output hsi_ctrl_pkg::err_code_t error_code
);

    import hsi_types_pkg::*;

    logic        in1_rd_en;
    logic        in2_rd_en;
    logic        in1_empty;
    logic        in2_empty;
    hsi_vec_t    in1_word;     // Input FIFO read data
    hsi_vec_t    in2_word;
    logic        cmd_valid;
    vec_cmd_t    cmd;          // Decode to execute
    logic        result_valid;
    hsi_result_u result;       // Execute to writer
    logic        out_wr_en;
    hsi_vec_t    out_word;     // Writer to output FIFO
    logic        written;      // Writer to decode

    vec_fifo #(.WIDTH($bits(hsi_vec_t))) fifo_in1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (in1_wr_en),
        .rd_en    (in1_rd_en),
        .data_in  (in1_data),
        .data_out (in1_word),
        .full     (in1_full),
        .empty    (in1_empty)
    );

    vec_fifo #(.WIDTH($bits(hsi_vec_t))) fifo_in2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (in2_wr_en),
        .rd_en    (in2_rd_en),
        .data_in  (in2_data),
        .data_out (in2_word),
        .full     (in2_full),
        .empty    (in2_empty)
    );

    vec_fifo #(.WIDTH($bits(hsi_vec_t))) fifo_out (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (out_wr_en),
        .rd_en    (out_rd_en),
        .data_in  (out_word),
        .data_out (out_data),
        .full     (out_full),
        .empty    (out_empty)
    );

    vector_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op_code    (op_code),
        .num_bands  (num_bands),
        .in1_empty  (in1_empty),
        .in2_empty  (in2_empty),
        .in1_word   (in1_word),
        .in2_word   (in2_word),
        .written    (written),
        .in1_rd_en  (in1_rd_en),
        .in2_rd_en  (in2_rd_en),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .error_code (error_code)
    );

    vector_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .result_valid (result_valid),
        .result       (result)
    );

    result_writer u_writer (
        .clk          (clk),
        .rst_n        (rst_n),
        .result_valid (result_valid),
        .result       (result),
        .out_full     (out_full),
        .out_wr_en    (out_wr_en),
        .out_word     (out_word),
        .pixel_done   (pixel_done),
        .written      (written)
    );

endmodule

`default_nettype wire

//--- hsi_vector_core_properties.sv
// Concurrent checks on the vector core top level, attached with bind from the testbench
`timescale 1ns/1ns
`default_nettype none

module hsi_vector_core_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    pixel_done,
    input logic                    in1_rd_en,  // Decode read strobes
    input logic                    in2_rd_en,
    input logic                    out_full,
    input logic                    out_empty,
    input hsi_ctrl_pkg::err_code_t error_code
);

    import hsi_ctrl_pkg::*;

    int fail_count = 0; // Failed checks, summed into the final verdict

    // Nothing moves while reset is held
    reset_quiet: assert property (@(posedge clk) !rst_n |-> !pixel_done && !in1_rd_en && !in2_rd_en)
        else begin
            $error("pixel_done or an input read strobe high during reset");
            fail_count++;
        end

    // One pulse per stored result
    done_single: assert property (@(posedge clk) disable iff (!rst_n) pixel_done |=> !pixel_done)
        else begin
            $error("pixel_done held longer than one cycle");
            fail_count++;
        end

    fill_flags: assert property (@(posedge clk) disable iff (!rst_n) !(out_full && out_empty))
        else begin
            $error("Output FIFO flagged full and empty at once");
            fail_count++;
        end

    // Results only come from accepted starts
    done_no_error: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_done |-> error_code == ERR_NONE)
        else begin
            $error("pixel_done pulsed while an error code was held");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- hsi_vector_patterns.txt
// mode op bands in1 in2 expected, hex, component 0 in the low 16 bits of each word
// mode 0 single pair, 1 burst pair, 2 start error (expected is the code), 3 stall run, f end
0 1 3 000300020001 000600050004 fffd0006fffd
0 1 3 000000000001 000000010000 000100000000
0 1 3 fffc0003fffe 0007fffa0005 fffdfffafffd
0 1 3 006400c8012c 0258fe0c0190 7d90dd209810
0 2 1 000900090007 00050005fffd 00000000ffeb
0 2 2 0063ffec000a 00630028001e 00000000fe0c
0 2 3 f44807d003e8 001400320064 0000000022e0
1 2 2 000000010001 000000030002 000000000005
1 2 2 00000004ffff 000000020006 000000000002
1 2 2 000000640064 0000ff9cff9c 00000000b1e0
1 2 2 000500000000 000500000000 000000000000
2 2 0 000000000000 000000000000 000000000004
2 1 2 000000000000 000000000000 000000000001
2 3 3 000000000000 000000000000 000000000001
2 2 2 000000000000 000000000000 000000000002
3 1 3 000000000000 000000000000 000000000000
f 0 0 000000000000 000000000000 000000000000

//--- result_writer.sv
// Output stage of the vector core: holds a result until the output FIFO has room, then writes it
`timescale 1ns/1ns
`default_nettype none

module result_writer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       result_valid,
    input  hsi_types_pkg::hsi_result_u result,
    input  logic                       out_full,   // Back-pressure from the output FIFO
    output logic                       out_wr_en,
    output hsi_types_pkg::hsi_vec_t    out_word,
    output logic                       pixel_done, // One pulse per stored result
    output logic                       written     // Completion back to decode
);

    logic pending; // Result waiting for room
    logic fire;    // Write goes out this cycle

    // Earliest write is the cycle after result_valid, later while the FIFO is full
    assign fire       = pending && !out_full;
    assign out_wr_en  = fire;
    assign pixel_done = fire;
    assign written    = fire;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (result_valid) begin
            pending <= 1'b1;
        end else if (fire) begin
            pending <= 1'b0; // Stored, next result comes only after decode restarts
        end
    end

    // Both result views share the bits, the word is stored as is
    always_ff @(posedge clk) begin
        if (result_valid) begin
            out_word <= result.vec;
        end
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
// Clock and power-on reset source for the vector core testbench, instanced once by the testbench top
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 10, // Clock period in ns
    parameter int RESET_CYCLES = 16  // Cycles with rst_n held low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1; // Released away from the active edge
    end

endmodule

`default_nettype wire

//--- tb_hsi_vector_core.sv
// Testbench top of the vector core, replays the pattern table and checks results and error codes
`timescale 1ns/1ns
`default_nettype none

`include "hsi_core_settings.svh"

module tb_hsi_vector_core;

    import hsi_types_pkg::*;
    import hsi_ctrl_pkg::*;

    localparam int         FIELDS       = 6;  // mode, op, bands, in1, in2, expected
    localparam int         MAX_LINES    = 64;
    localparam int         STALL_PAIRS  = `HSI_FIFO_DEPTH + 4; // Some beyond a full output FIFO
    localparam int         STALL_WINDOW = 24; // Cycles watched for a write while full
    localparam logic [3:0] MODE_SINGLE  = 4'h0;
    localparam logic [3:0] MODE_BURST   = 4'h1;
    localparam logic [3:0] MODE_ERROR   = 4'h2;
    localparam logic [3:0] MODE_STALL   = 4'h3;
    localparam logic [3:0] MODE_END     = 4'hf;

    logic       clk;
    logic       rst_n;
    logic       in1_wr_en;
    logic       in2_wr_en;
    logic       out_rd_en;
    logic       start;
    hsi_vec_t   in1_data;
    hsi_vec_t   in2_data;
    hsi_vec_t   out_data;
    op_code_t   op_code;
    logic [1:0] num_bands;
    logic       in1_full;
    logic       in2_full;
    logic       out_empty;
    logic       out_full;
    logic       pixel_done;
    err_code_t  error_code;

    logic [$bits(hsi_vec_t)-1:0] pat_mem [MAX_LINES*FIELDS]; // Six words per table line
    int     num_lines;
    int     line;
    int     group_len;
    int     error_count  = 0;
    int     done_count   = 0; // pixel_done pulses seen
    int     result_count = 0;
    int     cycle_count  = 0;
    int     cycle_limit  = 0; // Known once the table is loaded
    integer seed         = 32'h43256a5b;

    tb_clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    hsi_vector_core hsi_vector_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .in1_wr_en  (in1_wr_en),
        .in1_data   (in1_data),
        .in2_wr_en  (in2_wr_en),
        .in2_data   (in2_data),
        .out_rd_en  (out_rd_en),
        .op_code    (op_code),
        .num_bands  (num_bands),
        .start      (start),
        .in1_full   (in1_full),
        .in2_full   (in2_full),
        .out_data   (out_data),
        .out_empty  (out_empty),
        .out_full   (out_full),
        .pixel_done (pixel_done),
        .error_code (error_code)
    );

    bind hsi_vector_core hsi_vector_core_props u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .pixel_done (pixel_done),
        .in1_rd_en  (in1_rd_en),
        .in2_rd_en  (in2_rd_en),
        .out_full   (out_full),
        .out_empty  (out_empty),
        .error_code (error_code)
    );

    function automatic logic [3:0] field_nib(input int idx, input int field);
        return pat_mem[idx*FIELDS + field][3:0];
    endfunction

    function automatic hsi_vec_t field_word(input int idx, input int field);
        return pat_mem[idx*FIELDS + field];
    endfunction

    task automatic print_counts();
        $display("Errors: %0d, assertion failures: %0d, results read: %0d, cycles: %0d",
                 error_count, hsi_vector_core_i.u_props.fail_count, result_count, cycle_count);
    endtask

    task automatic report_mismatch(input string name, input logic [47:0] got,
                                   input logic [47:0] expected);
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        error_count++;
    endtask

    // Every advance goes through here so no pixel_done pulse is missed
    task automatic step();
        @(negedge clk);
        if (pixel_done) begin
            done_count++;
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 4; // Zero to three quiet cycles
        repeat (gap) step();
    endtask

    task automatic push_pair(input hsi_vec_t word_a, input hsi_vec_t word_b);
        while (in1_full || in2_full) begin
            step(); // Wait for room, a full FIFO drops writes
        end
        in1_data  = word_a;
        in2_data  = word_b;
        in1_wr_en = 1'b1;
        in2_wr_en = 1'b1;
        step();
        in1_wr_en = 1'b0;
        in2_wr_en = 1'b0;
    endtask

    task automatic pulse_start(input logic [3:0] op, input logic [3:0] bands);
        op_code   = op_code_t'(op);
        num_bands = bands[1:0];
        start     = 1'b1;
        step();
        start     = 1'b0;
    endtask

    // Read data shows up the cycle after the strobe
    task automatic read_result(input hsi_vec_t expected);
        while (out_empty) begin
            step();
        end
        out_rd_en = 1'b1;
        step();
        out_rd_en = 1'b0;
        result_count++;
        if (out_data !== expected) begin
            report_mismatch("out_data", out_data, expected);
        end
    endtask

    // Pairs queued first, then one start takes them all in order
    task automatic run_group(input int first, input int count);
        int done_before;
        done_before = done_count;
        for (int i = 0; i < count; i++) begin
            push_pair(field_word(first + i, 3), field_word(first + i, 4));
            idle_gap();
        end
        pulse_start(field_nib(first, 1), field_nib(first, 2));
        for (int i = 0; i < count; i++) begin
            read_result(field_word(first + i, 5));
        end
        if (done_count - done_before != count) begin
            report_mismatch("pixel_done count", 48'(done_count - done_before), 48'(count));
        end
        if (error_code !== ERR_NONE) begin
            report_mismatch("error_code", 48'(error_code), 48'(ERR_NONE));
        end
    endtask

    task automatic run_error(input int idx);
        int        done_before;
        err_code_t expected;
        done_before = done_count;
        expected    = err_code_t'(field_nib(idx, 5));
        op_code     = op_code_t'(field_nib(idx, 1));
        num_bands   = 2'(field_nib(idx, 2));
        start       = 1'b1;
        step();
        while (error_code == ERR_NONE) begin
            step();
        end
        if (error_code !== expected) begin
            report_mismatch("error_code", 48'(error_code), 48'(expected));
        end
        step();
        idle_gap();
        if (error_code !== expected) begin
            report_mismatch("error_code", 48'(error_code), 48'(expected)); // Held while start is high
        end
        start = 1'b0;
        while (error_code != ERR_NONE) begin
            step();
        end
        if (done_count != done_before) begin
            report_mismatch("pixel_done count", 48'(done_count - done_before), 48'(0));
        end
    endtask

    // Cross product lines replayed until the output FIFO fills and the core stalls
    task automatic run_stall(input int idx);
        int cross_lines[$];
        int done_before;
        int pick;
        for (int i = 0; i < num_lines; i++) begin
            if (field_nib(i, 0) == MODE_SINGLE && field_nib(i, 1) == OP_CROSS) begin
                cross_lines.push_back(i);
            end
        end
        if (cross_lines.size() == 0) begin
            report_failure("No cross product lines to replay in the stall run");
            return;
        end
        done_before = done_count;
        for (int i = 0; i < `HSI_FIFO_DEPTH; i++) begin
            pick = cross_lines[i % cross_lines.size()];
            push_pair(field_word(pick, 3), field_word(pick, 4));
        end
        if (in1_full !== 1'b1) begin
            report_mismatch("in1_full", 48'(in1_full), 48'(1));
        end
        if (in2_full !== 1'b1) begin
            report_mismatch("in2_full", 48'(in2_full), 48'(1));
        end
        pulse_start(field_nib(idx, 1), field_nib(idx, 2));
        for (int i = `HSI_FIFO_DEPTH; i < STALL_PAIRS; i++) begin
            pick = cross_lines[i % cross_lines.size()];
            push_pair(field_word(pick, 3), field_word(pick, 4)); // Core still busy
        end
        while (!out_full) begin
            step();
        end
        repeat (STALL_WINDOW) step();
        if (done_count - done_before != `HSI_FIFO_DEPTH) begin
            report_mismatch("pixel_done count", 48'(done_count - done_before),
                            48'(`HSI_FIFO_DEPTH));
        end
        for (int i = 0; i < STALL_PAIRS; i++) begin
            read_result(field_word(cross_lines[i % cross_lines.size()], 5));
        end
        if (done_count - done_before != STALL_PAIRS) begin
            report_mismatch("pixel_done count", 48'(done_count - done_before), 48'(STALL_PAIRS));
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        in1_wr_en = 1'b0;
        in2_wr_en = 1'b0;
        out_rd_en = 1'b0;
        start     = 1'b0;
        in1_data  = '0;
        in2_data  = '0;
        op_code   = OP_DOT;
        num_bands = 2'd0;
        $readmemh("hsi_vector_patterns.txt", pat_mem);
        num_lines = 0;
        while (num_lines < MAX_LINES && !$isunknown(field_nib(num_lines, 0)) &&
               field_nib(num_lines, 0) != MODE_END) begin
            num_lines++;
        end
        if (num_lines == MAX_LINES || field_nib(num_lines, 0) !== MODE_END) begin
            report_failure("Pattern table unreadable or missing its end line");
        end
        cycle_limit = 200 * num_lines + 500;
        @(posedge rst_n);
        step();
        if (error_code !== ERR_NONE) begin
            report_mismatch("error_code", 48'(error_code), 48'(ERR_NONE));
        end
        if (out_empty !== 1'b1) begin
            report_mismatch("out_empty", 48'(out_empty), 48'(1));
        end
        line = 0;
        while (line < num_lines) begin
            case (field_nib(line, 0))
                MODE_SINGLE: begin
                    run_group(line, 1);
                    line++;
                end
                MODE_BURST: begin
                    group_len = 1; // Consecutive burst lines form one group
                    while (line + group_len < num_lines &&
                           field_nib(line + group_len, 0) == MODE_BURST) begin
                        group_len++;
                    end
                    run_group(line, group_len);
                    line += group_len;
                end
                MODE_ERROR: begin
                    run_error(line);
                    line++;
                end
                MODE_STALL: begin
                    run_stall(line);
                    line++;
                end
                default: begin
                    report_failure($sformatf("Pattern entry %0d has an unknown mode", line));
                    line++;
                end
            endcase
            idle_gap();
        end
        print_counts();
        if (error_count == 0 && hsi_vector_core_i.u_props.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vec_fifo.sv
// Synchronous FIFO with registered read data, instanced for both pixel inputs and the result output
`timescale 1ns/1ns
`default_nettype none

`include "hsi_core_settings.svh"

module vec_fifo #(
    parameter int WIDTH = `HSI_COMP_W * `HSI_COMP_MAX, // Word width
    parameter int DEPTH = `HSI_FIFO_DEPTH              // Entries, any value from 2
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic             rd_en,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out, // Valid the cycle after a read
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH]; // Storage ring
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;       // Words held
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;  // Write to a full FIFO is dropped
    assign do_rd = rd_en && !empty; // Read of an empty FIFO is ignored

    // Ring step, also correct for a depth that is not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither, fill unchanged
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= data_in;
        end
        if (do_rd) begin
            data_out <= mem[rd_ptr]; // Registered read port
        end
    end

endmodule

`default_nettype wire

//--- vector_decode.sv
// Request FSM of the vector core: checks start, pulls input pixel pairs and issues commands
`timescale 1ns/1ns
`default_nettype none

module vector_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  hsi_ctrl_pkg::op_code_t  op_code,
    input  logic [1:0]              num_bands,
    input  logic                    in1_empty,
    input  logic                    in2_empty,
    input  hsi_types_pkg::hsi_vec_t in1_word,   // FIFO read data, valid in FETCH
    input  hsi_types_pkg::hsi_vec_t in2_word,
    input  logic                    written,    // Result of the current pair stored
    output logic                    in1_rd_en,
    output logic                    in2_rd_en,
    output logic                    cmd_valid,
    output hsi_types_pkg::vec_cmd_t cmd,
    output hsi_ctrl_pkg::err_code_t error_code
);

    import hsi_ctrl_pkg::*;

    decode_state_t state;
    decode_state_t next_state;
    err_code_t     start_err;  // Verdict of the start checks
    logic          bands_ok;
    logic          op_ok;
    logic          pair_ready; // Both inputs hold a pixel
    logic          pull;       // Read one pixel from each input

    assign pair_ready = !in1_empty && !in2_empty;
    assign bands_ok   = (num_bands != 2'd0) && (num_bands <= BANDS_MAX);
    assign op_ok      = (op_code == OP_DOT) ||
                        (op_code == OP_CROSS && num_bands == CROSS_BANDS);

    // Check order is bands, then op, then input fill
    always_comb begin
        if (!bands_ok) begin
            start_err = ERR_BANDS;
        end else if (!op_ok) begin
            start_err = ERR_OP;
        end else if (!pair_ready) begin
            start_err = ERR_INPUT_EMPTY;
        end else begin
            start_err = ERR_NONE;
        end
    end

    always_comb begin
        next_state = state;
        pull       = 1'b0;
        case (state)
            IDLE: begin
                if (start && start_err == ERR_NONE) begin
                    pull       = 1'b1; // Accepted, read data shows up in FETCH
                    next_state = FETCH;
                end else if (start) begin
                    next_state = ERROR;
                end
            end
            FETCH:     next_state = ISSUE;
            ISSUE:     next_state = WAIT_DONE;
            WAIT_DONE: begin
                if (written) begin
                    pull       = pair_ready;                // Keep going while data waits
                    next_state = pair_ready ? FETCH : IDLE;
                end
            end
            ERROR: begin
                if (!start) begin
                    next_state = IDLE;
                end
            end
            default:   next_state = IDLE;
        endcase
    end

    assign in1_rd_en = pull; // Both inputs always read as a pair
    assign in2_rd_en = pull;
    assign cmd_valid = (state == ISSUE); // One cycle, state leaves ISSUE at once

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            error_code <= ERR_NONE;
        end else begin
            state <= next_state;
            if (state == IDLE && start && start_err != ERR_NONE) begin
                error_code <= start_err;   // Held through ERROR
            end else if (state == ERROR && !start) begin
                error_code <= ERR_NONE;    // Start dropped, clear
            end
        end
    end

    // Op and band count latched at acceptance, pixels captured in FETCH
    always_ff @(posedge clk) begin
        if (state == IDLE && pull) begin
            cmd.op    <= op_code[1:0];
            cmd.bands <= num_bands;
        end
        if (state == FETCH) begin
            for (int k = 0; k < BANDS_MAX; k++) begin
                if (k < cmd.bands) begin
                    cmd.vec_a[k] <= in1_word[k];
                    cmd.vec_b[k] <= in2_word[k];
                end else begin
                    cmd.vec_a[k] <= '0; // Unused bands zeroed
                    cmd.vec_b[k] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- vector_execute.sv
// Arithmetic unit of the vector core: one-step cross product or band-serial dot product
`timescale 1ns/1ns
`default_nettype none

module vector_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cmd_valid,
    input  hsi_types_pkg::vec_cmd_t    cmd,          // Held by decode until written
    output logic                       result_valid,
    output hsi_types_pkg::hsi_result_u result
);

    import hsi_types_pkg::*;
    import hsi_ctrl_pkg::*;

    logic       busy;      // Dot product still walking the bands
    logic [1:0] band_idx;  // Band added this cycle
    logic       last_band; // Current band is the final one
    logic       is_cross;
    comp_t      dot_term;  // Wrapped product of one band pair

    // Operands come straight from cmd, decode does not change it before the write
    assign is_cross  = (cmd.op == 2'(OP_CROSS));
    assign last_band = (band_idx == cmd.bands - 2'd1);
    assign dot_term  = cmd.vec_a[band_idx] * cmd.vec_b[band_idx]; // Low 16 bits kept

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy         <= 1'b0;
            band_idx     <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (cmd_valid && is_cross) begin
                result_valid <= 1'b1;           // One cycle after cmd_valid
            end else if (cmd_valid || busy) begin
                if (last_band) begin
                    busy         <= 1'b0;
                    band_idx     <= '0;         // Ready for the next command
                    result_valid <= 1'b1;       // num_bands cycles after cmd_valid
                end else begin
                    busy     <= 1'b1;
                    band_idx <= band_idx + 2'd1;
                end
            end
        end
    end

    // Result word, all sums wrap to the component width
    always_ff @(posedge clk) begin
        if (cmd_valid && is_cross) begin
            result.vec[0] <= cmd.vec_a[1] * cmd.vec_b[2] - cmd.vec_a[2] * cmd.vec_b[1];
            result.vec[1] <= cmd.vec_a[2] * cmd.vec_b[0] - cmd.vec_a[0] * cmd.vec_b[2];
            result.vec[2] <= cmd.vec_a[0] * cmd.vec_b[1] - cmd.vec_a[1] * cmd.vec_b[0];
        end else if (cmd_valid) begin
            result.dot.pad <= '0;       // Components above 0 stay zero
            result.dot.sum <= dot_term; // Band 0 starts the sum
        end else if (busy) begin
            result.dot.sum <= result.dot.sum + dot_term;
        end
    end

endmodule

`default_nettype wire
